// File: source/sd_pkg.sv
`default_nettype none

package sd_pkg;

    // Width of the CIC accumulators and of the output words
    // Wide enough for a third-order filter at a decimation of up to 512
    localparam int ACC_WIDTH = 32;

    // Configuration write port widths
    localparam int CFG_ADDR_WIDTH = 2;
    localparam int CFG_DATA_WIDTH = 16;

    // Register map
    localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_CONTROL = 2'd0;
    localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_CLK_DIV = 2'd1;

    // Bit positions inside the control register
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_OVR_CLR_BIT = 1;

    // Modulator clock half-period minus one after reset
    localparam logic [CFG_DATA_WIDTH-1:0] CLK_DIV_RESET = 16'd3;

    // Decimated pairs thrown away after start while the combs fill up
    localparam int SETTLE_OUTPUTS = 3;

    // Number of integrator and comb stages
    localparam int CIC_ORDER = 3;

endpackage

`default_nettype wire

// File: source/sd_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module sd_clock_gen import sd_pkg::*; #(
    parameter int DECIMATION = 16
) (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      run,
    input  wire [CFG_DATA_WIDTH-1:0] clk_div,
    output logic                     sd_clk,
    output logic                     sample_stb,
    output logic                     dec_stb
);

    // Sample counter needs at least one bit even for a decimation of one
    localparam int SMP_W = (DECIMATION > 1) ? $clog2(DECIMATION) : 1;

    logic [CFG_DATA_WIDTH-1:0] half_cnt;
    logic [SMP_W-1:0]          smp_cnt;
    logic                      half_done;

    // The half period ends when the counter reaches the programmed divider
    assign half_done = (half_cnt == clk_div);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            half_cnt   <= '0;
            smp_cnt    <= '0;
            sd_clk     <= 1'b0;
            sample_stb <= 1'b0;
            dec_stb    <= 1'b0;
        end else if (!run) begin
            // Hold the modulator clock low and restart the decimation phase
            half_cnt   <= '0;
            smp_cnt    <= '0;
            sd_clk     <= 1'b0;
            sample_stb <= 1'b0;
            dec_stb    <= 1'b0;
        end else begin
            sample_stb <= 1'b0;
            dec_stb    <= 1'b0;
            if (half_done) begin
                half_cnt <= '0;
                sd_clk   <= ~sd_clk;
                // A high-to-low toggle is the falling edge where data is taken
                if (sd_clk) begin
                    sample_stb <= 1'b1;
                    // Every DECIMATION-th sample also marks a decimated output
                    if (smp_cnt == SMP_W'(DECIMATION - 1)) begin
                        smp_cnt <= '0;
                        dec_stb <= 1'b1;
                    end else begin
                        smp_cnt <= smp_cnt + 1'b1;
                    end
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/sd_control_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module sd_control_fsm import sd_pkg::*; (
    input  wire                       clk,
    input  wire                       arst_n,
    input  wire                       cfg_we,
    input  wire  [CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  wire  [CFG_DATA_WIDTH-1:0] cfg_wdata,
    input  wire                       sync,
    input  wire                       dec_stb,
    output logic                      run,
    output logic [CFG_DATA_WIDTH-1:0] clk_div,
    output logic                      cic_clear,
    output logic                      emit,
    output logic                      overrun_clear
);

    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_WAIT_SYNC = 2'd1;
    localparam logic [1:0] ST_SETTLE    = 2'd2;
    localparam logic [1:0] ST_RUN       = 2'd3;

    localparam int SET_W = $clog2(SETTLE_OUTPUTS + 1);

    logic [1:0]       state;
    logic             enable;
    logic [SET_W-1:0] settle_cnt;
    logic             ctrl_write;

    assign ctrl_write = cfg_we && (cfg_addr == ADDR_CONTROL);

    // Configuration registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable        <= 1'b0;
            clk_div       <= CLK_DIV_RESET;
            overrun_clear <= 1'b0;
        end else begin
            // The clear request lasts a single cycle after the write
            overrun_clear <= ctrl_write && cfg_wdata[CTRL_OVR_CLR_BIT];
            if (ctrl_write) begin
                enable <= cfg_wdata[CTRL_ENABLE_BIT];
            end
            if (cfg_we && (cfg_addr == ADDR_CLK_DIV)) begin
                clk_div <= cfg_wdata;
            end
        end
    end

    // Sequencing of start-up, settling and normal operation
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ST_IDLE;
            settle_cnt <= '0;
        end else if (!enable) begin
            // Dropping enable aborts whatever is going on
            state      <= ST_IDLE;
            settle_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    state <= ST_WAIT_SYNC;
                end
                ST_WAIT_SYNC: begin
                    settle_cnt <= '0;
                    if (sync) begin
                        state <= ST_SETTLE;
                    end
                end
                ST_SETTLE: begin
                    // Count the transient outputs while the comb delays fill
                    if (dec_stb) begin
                        if (settle_cnt == SET_W'(SETTLE_OUTPUTS - 1)) begin
                            state <= ST_RUN;
                        end else begin
                            settle_cnt <= settle_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_RUN;
                end
            endcase
        end
    end

    // Outputs decode straight from the state register
    assign cic_clear = (state == ST_IDLE);
    assign run       = (state == ST_SETTLE) || (state == ST_RUN);
    assign emit      = (state == ST_RUN);

endmodule

`default_nettype wire

// File: source/cic_decimator.sv
`timescale 1ns/10ps
`default_nettype none

module cic_decimator import sd_pkg::*; #(
    parameter int DECIMATION = 16
) (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         cic_clear,
    input  wire                         sample_stb,
    input  wire                         dec_stb,
    input  wire                         bit_in,
    output logic signed [ACC_WIDTH-1:0] sample_out,
    output logic                        out_stb
);

    // Register growth of an N-stage CIC with a two-bit signed input
    // Wrapping arithmetic is exact as long as the final value fits this width
    localparam int REG_WIDTH = CIC_ORDER * $clog2(DECIMATION) + 2;

    logic signed [REG_WIDTH-1:0] step;
    logic signed [REG_WIDTH-1:0] integ      [CIC_ORDER];
    logic signed [REG_WIDTH-1:0] integ_next [CIC_ORDER];
    logic signed [REG_WIDTH-1:0] comb_dly   [CIC_ORDER];
    logic signed [REG_WIDTH-1:0] comb_val   [CIC_ORDER+1];

    always_comb begin
        // A one in the bitstream stands for +1 and a zero for -1
        step = bit_in ? REG_WIDTH'(1) : '1;
        // Integrators chain without pipeline delay so the decimated value
        // already contains the current sample
        integ_next[0] = integ[0] + step;
        for (int k = 1; k < CIC_ORDER; k++) begin
            integ_next[k] = integ[k] + integ_next[k-1];
        end
        // Comb differences at the decimated rate
        comb_val[0] = integ_next[CIC_ORDER-1];
        for (int k = 0; k < CIC_ORDER; k++) begin
            comb_val[k+1] = comb_val[k] - comb_dly[k];
        end
    end

    always_ff @(posedge clk) begin
        if (cic_clear) begin
            for (int k = 0; k < CIC_ORDER; k++) begin
                integ[k]    <= '0;
                comb_dly[k] <= '0;
            end
        end else begin
            if (sample_stb) begin
                for (int k = 0; k < CIC_ORDER; k++) begin
                    integ[k] <= integ_next[k];
                end
            end
            if (dec_stb) begin
                for (int k = 0; k < CIC_ORDER; k++) begin
                    comb_dly[k] <= comb_val[k];
                end
            end
        end
        // Output word is sign extended to the stream width
        if (dec_stb) begin
            sample_out <= ACC_WIDTH'(comb_val[CIC_ORDER]);
        end
    end

    // Output strobe trails the decimation strobe by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_stb <= 1'b0;
        end else begin
            out_stb <= dec_stb && !cic_clear;
        end
    end

endmodule

`default_nettype wire

// File: source/sd_output_queue.sv
`timescale 1ns/10ps
`default_nettype none

module sd_output_queue import sd_pkg::*; #(
    parameter int CREDITS = 4
) (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         emit,
    input  wire                         overrun_clear,
    input  wire  signed [ACC_WIDTH-1:0] sample_0,
    input  wire  signed [ACC_WIDTH-1:0] sample_1,
    input  wire                         in_stb,
    input  wire                         credit_return,
    output logic                        out_valid,
    output logic signed [ACC_WIDTH-1:0] out_data,
    output logic                        out_dest,
    output logic                        overrun
);

    localparam int DEPTH  = 4;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(CREDITS + 1);

    logic signed [ACC_WIDTH-1:0] data_mem [DEPTH];
    logic                        dest_mem [DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  wr_ptr_nxt;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;
    logic [CRED_W-1:0] credits_spent;
    logic              push;
    logic              fits;
    logic              store;

    // A word leaves whenever one is queued and the receiver has room
    assign out_valid = (count != '0) && (credits != '0);
    assign out_data  = data_mem[rd_ptr];
    assign out_dest  = dest_mem[rd_ptr];

    // Room for a pair counts the slot freed by a read in the same cycle
    assign push       = in_stb && emit;
    assign fits       = (count <= CNT_W'(DEPTH - 2 + int'(out_valid)));
    assign store      = push && fits;
    assign wr_ptr_nxt = wr_ptr + 1'b1;

    // Pair storage, channel 0 first so it is read out first
    always_ff @(posedge clk) begin
        if (store) begin
            data_mem[wr_ptr]     <= sample_0;
            dest_mem[wr_ptr]     <= 1'b0;
            data_mem[wr_ptr_nxt] <= sample_1;
            dest_mem[wr_ptr_nxt] <= 1'b1;
        end
    end

    // Queue pointers and fill level
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (store) begin
                wr_ptr <= wr_ptr + 2'd2;
            end
            if (out_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({store, out_valid})
                2'b10:   count <= count + 2'd2;
                2'b11:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Credits left after this cycle's transfer
    assign credits_spent = credits - CRED_W'(out_valid);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CRED_W'(CREDITS);
        end else if (credit_return && (credits_spent != CRED_W'(CREDITS))) begin
            credits <= credits_spent + 1'b1;
        end else begin
            // Returns beyond the receiver depth are ignored
            credits <= credits_spent;
        end
    end

    // Sticky overrun flag, a new drop wins over a clear in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            overrun <= 1'b0;
        end else if (push && !fits) begin
            overrun <= 1'b1;
        end else if (overrun_clear) begin
            overrun <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/sd_processor.sv
`timescale 1ns/10ps
`default_nettype none

module sd_processor import sd_pkg::*; #(
    parameter int DECIMATION = 16,
    parameter int CREDITS    = 4
) (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         cfg_we,
    input  wire  [CFG_ADDR_WIDTH-1:0]   cfg_addr,
    input  wire  [CFG_DATA_WIDTH-1:0]   cfg_wdata,
    input  wire                         sync,
    input  wire  [1:0]                  sd_data,
    input  wire                         credit_return,
    output logic                        sd_clk,
    output logic                        out_valid,
    output logic signed [ACC_WIDTH-1:0] out_data,
    output logic                        out_dest,
    output logic                        overrun
);

    wire                        run;
    wire [CFG_DATA_WIDTH-1:0]   clk_div;
    wire                        cic_clear;
    wire                        emit;
    wire                        overrun_clear;
    wire                        sample_stb;
    wire                        dec_stb;
    wire signed [ACC_WIDTH-1:0] sample_0;
    wire signed [ACC_WIDTH-1:0] sample_1;
    wire                        pair_stb;

    // Configuration registers and run sequencing
    sd_control_fsm i_sd_control_fsm (
        .clk           (clk),
        .arst_n        (arst_n),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .sync          (sync),
        .dec_stb       (dec_stb),
        .run           (run),
        .clk_div       (clk_div),
        .cic_clear     (cic_clear),
        .emit          (emit),
        .overrun_clear (overrun_clear)
    );

    // Modulator clock and sample timing shared by both channels
    sd_clock_gen #(
        .DECIMATION (DECIMATION)
    ) i_sd_clock_gen (
        .clk        (clk),
        .arst_n     (arst_n),
        .run        (run),
        .clk_div    (clk_div),
        .sd_clk     (sd_clk),
        .sample_stb (sample_stb),
        .dec_stb    (dec_stb)
    );

    // Both filters run on the same strobes, so channel 0 paces the queue
    cic_decimator #(
        .DECIMATION (DECIMATION)
    ) i_cic_0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .cic_clear  (cic_clear),
        .sample_stb (sample_stb),
        .dec_stb    (dec_stb),
        .bit_in     (sd_data[0]),
        .sample_out (sample_0),
        .out_stb    (pair_stb)
    );

    cic_decimator #(
        .DECIMATION (DECIMATION)
    ) i_cic_1 (
        .clk        (clk),
        .arst_n     (arst_n),
        .cic_clear  (cic_clear),
        .sample_stb (sample_stb),
        .dec_stb    (dec_stb),
        .bit_in     (sd_data[1]),
        .sample_out (sample_1),
        .out_stb    ()
    );

    // Tagging, buffering and credit accounting of the output stream
    sd_output_queue #(
        .CREDITS (CREDITS)
    ) i_sd_output_queue (
        .clk           (clk),
        .arst_n        (arst_n),
        .emit          (emit),
        .overrun_clear (overrun_clear),
        .sample_0      (sample_0),
        .sample_1      (sample_1),
        .in_stb        (pair_stb),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_dest      (out_dest),
        .overrun       (overrun)
    );

endmodule

`default_nettype wire

// File: tb/sd_tb_tasks.svh
`ifndef SD_TB_TASKS_SVH
`define SD_TB_TASKS_SVH

// Clock cycles between two decimated outputs at the current divider
function automatic int dec_cycles();
    return DECIMATION * 2 * (div_now + 1);
endfunction

task automatic value_error(input string name, input longint expected, input longint actual);
    errors++;
    $display("ERR %0t: %s expected %0d, got %0d", $time, name, expected, actual);
endtask

task automatic fault(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
endtask

task automatic write_reg(input logic [CFG_ADDR_WIDTH-1:0] addr,
                         input logic [CFG_DATA_WIDTH-1:0] data);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we    = 1'b0;
endtask

task automatic idle_cycles(input int n);
    for (int k = 0; k < n; k++) begin
        @(negedge clk);
    end
endtask

// Waits until the receiver has logged n words in total
task automatic wait_words(input int n, input int limit);
    int k;
    k = 0;
    while ((word_data.size() < n) && (k < limit)) begin
        @(negedge clk);
        k++;
    end
    if (word_data.size() < n) begin
        fault($sformatf("timed out after %0d cycles with %0d of %0d words",
                        k, word_data.size(), n));
    end
endtask

task automatic start_run();
    write_reg(ADDR_CONTROL, 16'h0001);
    sync = 1'b1;
endtask

// Disables the design and lets the queue and pending credits run dry
task automatic stop_run();
    int quiet;
    int k;
    write_reg(ADDR_CONTROL, 16'h0000);
    sync         = 1'b0;
    hold_credits = 1'b0;
    quiet = 0;
    k     = 0;
    while ((quiet < 8) && (k < 2000)) begin
        @(negedge clk);
        k++;
        if (out_valid || (owed_credits != 0) || (credit_dly != 2'b00)) begin
            quiet = 0;
        end else begin
            quiet++;
        end
    end
    if (quiet < 8) begin
        fault("output stream did not go quiet after enable was cleared");
    end
    word_data.delete();
    word_dest.delete();
endtask

// Words must alternate dest 0 and dest 1 with +level on 0 and -level on 1
task automatic compare_words(input int count, input longint level);
    logic   exp_dest;
    longint exp_data;
    for (int i = 0; (i < count) && (i < word_data.size()); i++) begin
        exp_dest = (i % 2) == 1;
        exp_data = exp_dest ? -level : level;
        if (word_dest[i] !== exp_dest) begin
            value_error($sformatf("out_dest word %0d", i), exp_dest, word_dest[i]);
        end
        if (word_data[i] !== exp_data) begin
            value_error($sformatf("out_data word %0d", i), exp_data, word_data[i]);
        end
    end
endtask

task automatic measure_divider();
    integer rnd;
    int     div;
    int     edges;
    int     cycles;
    int     k;
    logic   prev;
    rnd = $random(seed);
    div = 1 + ((rnd & 32'h7fff_ffff) % 7);
    $display("Divider test with clk_div %0d", div);
    write_reg(ADDR_CLK_DIV, CFG_DATA_WIDTH'(div));
    div_now = div;
    start_run();
    prev   = sd_clk;
    edges  = 0;
    cycles = 0;
    k      = 0;
    // Cycles are counted from one rising sd_clk edge to the next
    while ((edges < 6) && (k < 1000)) begin
        @(negedge clk);
        k++;
        cycles++;
        if (sd_clk && !prev) begin
            if ((edges > 0) && (cycles != 2 * (div + 1))) begin
                value_error("sd_clk period", 2 * (div + 1), cycles);
            end
            edges++;
            cycles = 0;
        end
        prev = sd_clk;
    end
    if (edges < 6) begin
        fault("sd_clk stopped toggling during the divider test");
    end
    stop_run();
    write_reg(ADDR_CLK_DIV, CFG_DATA_WIDTH'(NOMINAL_DIV));
    div_now = NOMINAL_DIV;
endtask

task automatic run_constant_input();
    alternate = 1'b0;
    start_run();
    wait_words(8, 12 * dec_cycles());
    compare_words(8, FULL_SCALE);
    stop_run();
endtask

// An even decimation factor nulls a per-sample alternating input
task automatic run_alternating_input();
    alternate = 1'b1;
    start_run();
    wait_words(8, 12 * dec_cycles());
    compare_words(8, 0);
    stop_run();
    alternate = 1'b0;
endtask

task automatic verify_start_stop();
    logic clk_seen;
    alternate = 1'b0;
    sync      = 1'b0;
    write_reg(ADDR_CONTROL, 16'h0001);
    clk_seen = 1'b0;
    // Enabled but without sync nothing may move
    for (int k = 0; k < 3 * dec_cycles(); k++) begin
        @(negedge clk);
        clk_seen = clk_seen | sd_clk;
    end
    if (clk_seen) begin
        fault("sd_clk ran before sync was seen");
    end
    if (word_data.size() != 0) begin
        value_error("words before sync", 0, word_data.size());
    end
    sync = 1'b1;
    wait_words(6, 12 * dec_cycles());
    compare_words(6, FULL_SCALE);
    stop_run();
    clk_seen = 1'b0;
    for (int k = 0; k < 4 * dec_cycles(); k++) begin
        @(negedge clk);
        clk_seen = clk_seen | sd_clk;
    end
    if (clk_seen) begin
        fault("sd_clk kept running after enable was cleared");
    end
    if (word_data.size() != 0) begin
        value_error("words after stop", 0, word_data.size());
    end
    // The restart must deliver settled values from the first word on
    start_run();
    wait_words(4, 12 * dec_cycles());
    compare_words(4, FULL_SCALE);
    stop_run();
endtask

task automatic stall_on_credits();
    hold_credits = 1'b1;
    start_run();
    wait_words(CREDITS, 12 * dec_cycles());
    idle_cycles(3 * dec_cycles());
    if (word_data.size() != CREDITS) begin
        value_error("words without credits", CREDITS, word_data.size());
    end
    if (out_valid !== 1'b0) begin
        value_error("out_valid", 0, out_valid);
    end
    hold_credits = 1'b0;
    wait_words(CREDITS + 8, 6 * dec_cycles());
    compare_words(CREDITS + 8, FULL_SCALE);
    stop_run();
endtask

task automatic raise_and_clear_overrun();
    int k;
    write_reg(ADDR_CONTROL, 16'h0002);
    idle_cycles(2);
    if (overrun !== 1'b0) begin
        value_error("overrun", 0, overrun);
    end
    hold_credits = 1'b1;
    start_run();
    k = 0;
    while (!overrun && (k < 16 * dec_cycles())) begin
        @(negedge clk);
        k++;
    end
    if (!overrun) begin
        fault("overrun did not rise while credits were withheld");
    end
    // Once credits flow again the queue drains and no further pair is dropped
    // The flag is sticky, so it stays up until software clears it
    hold_credits = 1'b0;
    idle_cycles(2 * dec_cycles());
    if (overrun !== 1'b1) begin
        value_error("overrun", 1, overrun);
    end
    write_reg(ADDR_CONTROL, 16'h0003);
    k = 0;
    while (overrun && (k < 8)) begin
        @(negedge clk);
        k++;
    end
    if (overrun !== 1'b0) begin
        value_error("overrun", 0, overrun);
    end
    // With credits flowing again no pair gets dropped
    idle_cycles(2 * dec_cycles());
    if (overrun !== 1'b0) begin
        value_error("overrun", 0, overrun);
    end
    stop_run();
endtask

`endif

// File: tb/sd_processor_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sd_processor_tb import sd_pkg::*; ();

    localparam int DECIMATION  = 16;
    localparam int CREDITS     = 4;
    // Divider used by every test except the divider sweep
    localparam int NOMINAL_DIV = 3;
    // A constant +1 input settles at DECIMATION cubed for a third-order CIC
    localparam longint FULL_SCALE = DECIMATION * DECIMATION * DECIMATION;

    logic                      clk = 1'b0;
    logic                      arst_n;
    logic                      cfg_we;
    logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
    logic [CFG_DATA_WIDTH-1:0] cfg_wdata;
    logic                      sync;
    logic [1:0]                sd_data = 2'b01;
    logic                      credit_return = 1'b0;
    wire                       sd_clk;
    wire                       out_valid;
    wire signed [ACC_WIDTH-1:0] out_data;
    wire                       out_dest;
    wire                       overrun;

    integer seed = 32'h5222;
    int     errors = 0;
    int     total_words = 0;
    int     div_now = NOMINAL_DIV;

    // Modulator model state
    logic alternate = 1'b0;
    logic sd_clk_q = 1'b0;

    // Receiver model state
    logic       hold_credits = 1'b0;
    int         owed_credits = 0;
    logic [1:0] credit_dly = 2'b00;
    logic signed [ACC_WIDTH-1:0] word_data [$];
    logic                        word_dest [$];

    sd_processor #(
        .DECIMATION (DECIMATION),
        .CREDITS    (CREDITS)
    ) i_sd_processor (
        .clk           (clk),
        .arst_n        (arst_n),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .sync          (sync),
        .sd_data       (sd_data),
        .credit_return (credit_return),
        .sd_clk        (sd_clk),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_dest      (out_dest),
        .overrun       (overrun)
    );

    always #2 clk = ~clk;

    // Bitstream source, channel 1 always carries the inverse of channel 0
    // In alternating mode the pattern flips at every rising sd_clk edge
    always @(negedge clk) begin
        if (!alternate) begin
            sd_data = 2'b01;
        end else if (sd_clk && !sd_clk_q) begin
            sd_data = ~sd_data;
        end
        sd_clk_q = sd_clk;
    end

    // Receiver that logs every word and hands its credit back two cycles later
    // Credits owed while returns are held are paid back one per cycle afterwards
    always @(negedge clk) begin
        credit_return = 1'b0;
        if (arst_n) begin
            if (credit_dly[1]) begin
                owed_credits++;
            end
            if (!hold_credits && (owed_credits > 0)) begin
                credit_return = 1'b1;
                owed_credits--;
            end
            credit_dly = {credit_dly[0], out_valid};
            if (out_valid) begin
                word_data.push_back(out_data);
                word_dest.push_back(out_dest);
                total_words++;
            end
        end
    end

    `include "sd_tb_tasks.svh"

    initial begin
        arst_n    = 1'b0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        sync      = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        idle_cycles(4);

        measure_divider();
        run_constant_input();
        run_alternating_input();
        verify_start_stop();
        stall_on_credits();
        raise_and_clear_overrun();

        $display("Tests done: %0d errors, %0d words received", errors, total_words);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+tb
source/sd_pkg.sv
source/sd_clock_gen.sv
source/sd_control_fsm.sv
source/cic_decimator.sv
source/sd_output_queue.sv
source/sd_processor.sv
tb/sd_processor_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module sd_processor_tb -o sd_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sd_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0
